//--- rtl/gpio.sv
// --------------------------------------------------
// GPIO with output and enable registers, synchronized
// inputs and rising-edge interrupt status
// --------------------------------------------------
`timescale 1ns/1ps

module gpio (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  periph_pkg::reg_req_t          reg_req_i,
  output periph_pkg::reg_rsp_t          reg_rsp_o,
  input  logic [periph_pkg::GPIO_W-1:0] gpio_i,
  output logic [periph_pkg::GPIO_W-1:0] gpio_o,
  output logic [periph_pkg::GPIO_W-1:0] gpio_oe_o,
  output logic                          intr_o
);

  logic                            wr_en;
  logic [periph_pkg::SEL_LSB-1:0]  offset;
  logic [periph_pkg::GPIO_W-1:0]   out_q;
  logic [periph_pkg::GPIO_W-1:0]   oe_q;
  logic [periph_pkg::GPIO_W-1:0]   intr_en_q;
  logic [periph_pkg::GPIO_W-1:0]   status_q;
  logic [periph_pkg::GPIO_W-1:0]   sync1_q;
  logic [periph_pkg::GPIO_W-1:0]   sync2_q;
  logic [periph_pkg::GPIO_W-1:0]   prev_q;
  logic [periph_pkg::GPIO_W-1:0]   rise;
  logic [periph_pkg::GPIO_W-1:0]   status_clr;

  assign wr_en  = reg_req_i.valid & reg_req_i.write;
  assign offset = reg_req_i.addr[periph_pkg::SEL_LSB-1:0];

  assign rise = sync2_q & ~prev_q & intr_en_q;
  assign status_clr = (wr_en && offset == periph_pkg::GPIO_INTR_STATUS_OFFSET) ?
                      reg_req_i.wdata[periph_pkg::GPIO_W-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      // A new edge wins over a clear in the same cycle
      status_q <= (status_q & ~status_clr) | rise;
      if (wr_en) begin
        case (offset)
          periph_pkg::GPIO_OUT_OFFSET:     out_q <= reg_req_i.wdata[periph_pkg::GPIO_W-1:0];
          periph_pkg::GPIO_OE_OFFSET:      oe_q <= reg_req_i.wdata[periph_pkg::GPIO_W-1:0];
          periph_pkg::GPIO_INTR_EN_OFFSET: intr_en_q <= reg_req_i.wdata[periph_pkg::GPIO_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (offset)
      periph_pkg::GPIO_OUT_OFFSET:         reg_rsp_o.rdata = 32'(out_q);
      periph_pkg::GPIO_OE_OFFSET:          reg_rsp_o.rdata = 32'(oe_q);
      periph_pkg::GPIO_IN_OFFSET:          reg_rsp_o.rdata = 32'(sync2_q);
      periph_pkg::GPIO_INTR_EN_OFFSET:     reg_rsp_o.rdata = 32'(intr_en_q);
      periph_pkg::GPIO_INTR_STATUS_OFFSET: reg_rsp_o.rdata = 32'(status_q);
      default:                             reg_rsp_o.rdata = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign intr_o    = |status_q;

endmodule : gpio

//--- rtl/obi_to_reg.sv
// --------------------------------------------------
// Bus bridge: grants requests, registers them onto
// the register bus and returns the responses
// --------------------------------------------------
`timescale 1ns/1ps

module obi_to_reg (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  periph_pkg::obi_req_t  obi_req_i,
  output periph_pkg::obi_resp_t obi_resp_o,
  output periph_pkg::reg_req_t  reg_req_o,
  input  logic [31:0]           reg_rdata_i,
  input  logic                  reg_rvalid_i
);

  logic        ready_q;
  logic        accept;
  logic        valid_q;
  logic        write_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;

  // One request per cycle once out of reset
  assign accept = obi_req_i.req & ready_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
      valid_q <= accept;
    end
  end

  // Access held on the register bus for the cycle after acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      write_q <= obi_req_i.we;
      addr_q  <= obi_req_i.addr;
      wdata_q <= obi_req_i.wdata;
    end
  end

  always_comb begin
    reg_req_o.valid = valid_q;
    reg_req_o.write = write_q;
    reg_req_o.addr  = addr_q;
    reg_req_o.wdata = wdata_q;
  end

  // Response stage lives in the decoder
  always_comb begin
    obi_resp_o.gnt    = accept;
    obi_resp_o.rvalid = reg_rvalid_i;
    obi_resp_o.rdata  = reg_rdata_i;
  end

endmodule : obi_to_reg

//--- rtl/periph_pkg.sv
// --------------------------------------------------
// Peripheral subsystem shared bus types, address map
// and register offsets
// --------------------------------------------------
package periph_pkg;

  // Request as issued by the bus master
  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  // Slaves are always ready, so read data is all that comes back
  typedef struct packed {
    logic [31:0] rdata;
  } reg_rsp_t;

  // Slot map
  localparam int unsigned NUM_PERIPH = 4;
  localparam int unsigned PLIC_IDX = 0;
  localparam int unsigned GPIO_IDX = 1;
  localparam int unsigned TIMER_IDX = 2;
  localparam int unsigned UNMAPPED_IDX = 3;
  localparam int unsigned SEL_LSB = 8;
  localparam int unsigned SEL_W = $clog2(NUM_PERIPH);
  localparam logic [31:0] DEC_ERR_DATA = 32'hDEAD_BEEF;

  localparam int unsigned GPIO_W = 8;
  localparam int unsigned NEXT_INT = 4;
  // ID 0 reserved, then GPIO, timer and the external lines
  localparam int unsigned NUM_SRC = 3 + NEXT_INT;

  // Offsets inside a slot
  localparam logic [SEL_LSB-1:0] GPIO_OUT_OFFSET = 8'h00;
  localparam logic [SEL_LSB-1:0] GPIO_OE_OFFSET = 8'h04;
  localparam logic [SEL_LSB-1:0] GPIO_IN_OFFSET = 8'h08;
  localparam logic [SEL_LSB-1:0] GPIO_INTR_EN_OFFSET = 8'h0C;
  localparam logic [SEL_LSB-1:0] GPIO_INTR_STATUS_OFFSET = 8'h10;

  localparam logic [SEL_LSB-1:0] TIMER_COUNT_OFFSET = 8'h00;
  localparam logic [SEL_LSB-1:0] TIMER_COMPARE_OFFSET = 8'h04;
  localparam logic [SEL_LSB-1:0] TIMER_CTRL_OFFSET = 8'h08;
  localparam logic [SEL_LSB-1:0] TIMER_STATUS_OFFSET = 8'h0C;

  localparam logic [SEL_LSB-1:0] PLIC_PENDING_OFFSET = 8'h00;
  localparam logic [SEL_LSB-1:0] PLIC_ENABLE_OFFSET = 8'h04;
  localparam logic [SEL_LSB-1:0] PLIC_CLAIM_OFFSET = 8'h08;
  localparam logic [SEL_LSB-1:0] PLIC_MSIP_OFFSET = 8'h0C;

endpackage : periph_pkg

//--- rtl/peripheral_subsystem.sv
// --------------------------------------------------
// Peripheral subsystem top: bus bridge, decoder,
// GPIO, timer and interrupt controller
// --------------------------------------------------
`timescale 1ns/1ps

module peripheral_subsystem (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  periph_pkg::obi_req_t            obi_req_i,
  output periph_pkg::obi_resp_t           obi_resp_o,
  input  logic [periph_pkg::NEXT_INT-1:0] intr_ext_i,
  output logic                            irq_plic_o,
  output logic                            msip_o,
  input  logic [periph_pkg::GPIO_W-1:0]   gpio_i,
  output logic [periph_pkg::GPIO_W-1:0]   gpio_o,
  output logic [periph_pkg::GPIO_W-1:0]   gpio_oe_o
);

  periph_pkg::reg_req_t                              periph_req;
  logic [31:0]                                       periph_rdata;
  logic                                              periph_rvalid;
  periph_pkg::reg_req_t [periph_pkg::NUM_PERIPH-1:0] slv_req;
  periph_pkg::reg_rsp_t [periph_pkg::NUM_PERIPH-1:0] slv_rsp;
  logic                                              gpio_intr;
  logic                                              timer_intr;
  logic [periph_pkg::NUM_SRC-1:0]                    intr_src;

  // ID 0 is reserved and tied low
  assign intr_src = {intr_ext_i, timer_intr, gpio_intr, 1'b0};

  // Nothing behind the unmapped slot
  assign slv_rsp[periph_pkg::UNMAPPED_IDX] = '0;

  obi_to_reg obi_to_reg0 (
    .clk_i,
    .rst_n_i,
    .obi_req_i,
    .obi_resp_o,
    .reg_req_o   (periph_req),
    .reg_rdata_i (periph_rdata),
    .reg_rvalid_i(periph_rvalid)
  );

  reg_demux reg_demux0 (
    .clk_i,
    .rst_n_i,
    .reg_req_i   (periph_req),
    .reg_rdata_o (periph_rdata),
    .reg_rvalid_o(periph_rvalid),
    .slv_req_o   (slv_req),
    .slv_rsp_i   (slv_rsp)
  );

  plic_lite plic_lite0 (
    .clk_i,
    .rst_n_i,
    .reg_req_i (slv_req[periph_pkg::PLIC_IDX]),
    .reg_rsp_o (slv_rsp[periph_pkg::PLIC_IDX]),
    .intr_src_i(intr_src),
    .irq_o     (irq_plic_o),
    .msip_o
  );

  gpio gpio0 (
    .clk_i,
    .rst_n_i,
    .reg_req_i(slv_req[periph_pkg::GPIO_IDX]),
    .reg_rsp_o(slv_rsp[periph_pkg::GPIO_IDX]),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .intr_o   (gpio_intr)
  );

  timer timer0 (
    .clk_i,
    .rst_n_i,
    .reg_req_i(slv_req[periph_pkg::TIMER_IDX]),
    .reg_rsp_o(slv_rsp[periph_pkg::TIMER_IDX]),
    .intr_o   (timer_intr)
  );

endmodule : peripheral_subsystem

//--- rtl/plic_lite.sv
// --------------------------------------------------
// Small interrupt controller: pending latches,
// enables, claim by read and a software interrupt
// --------------------------------------------------
`timescale 1ns/1ps

module plic_lite (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  periph_pkg::reg_req_t           reg_req_i,
  output periph_pkg::reg_rsp_t           reg_rsp_o,
  input  logic [periph_pkg::NUM_SRC-1:0] intr_src_i,
  output logic                           irq_o,
  output logic                           msip_o
);

  logic                           wr_en;
  logic                           claim_rd;
  logic [periph_pkg::SEL_LSB-1:0] offset;
  logic [periph_pkg::NUM_SRC-1:0] pending_q;
  logic [periph_pkg::NUM_SRC-1:0] enable_q;
  logic                           msip_q;
  logic [periph_pkg::NUM_SRC-1:0] active;
  logic [periph_pkg::NUM_SRC-1:0] claim_oh;
  logic [periph_pkg::NUM_SRC-1:0] src_masked;
  logic [31:0]                    claim_id;

  assign wr_en    = reg_req_i.valid & reg_req_i.write;
  assign offset   = reg_req_i.addr[periph_pkg::SEL_LSB-1:0];
  assign claim_rd = reg_req_i.valid && !reg_req_i.write &&
                    (offset == periph_pkg::PLIC_CLAIM_OFFSET);

  // Source 0 never latches
  assign src_masked = {intr_src_i[periph_pkg::NUM_SRC-1:1], 1'b0};
  assign active     = pending_q & enable_q;

  // Lowest enabled pending ID, 0 when none
  always_comb begin
    claim_id = '0;
    claim_oh = '0;
    for (int i = periph_pkg::NUM_SRC - 1; i >= 1; i--) begin
      if (active[i]) begin
        claim_id    = 32'(i);
        claim_oh    = '0;
        claim_oh[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      msip_q    <= 1'b0;
    end else begin
      // Claim clears at the access edge, a live source sets it again next cycle
      pending_q <= (pending_q | src_masked) & ~(claim_rd ? claim_oh : '0);
      if (wr_en && offset == periph_pkg::PLIC_ENABLE_OFFSET) begin
        enable_q <= reg_req_i.wdata[periph_pkg::NUM_SRC-1:0];
      end
      if (wr_en && offset == periph_pkg::PLIC_MSIP_OFFSET) begin
        msip_q <= reg_req_i.wdata[0];
      end
    end
  end

  always_comb begin
    case (offset)
      periph_pkg::PLIC_PENDING_OFFSET: reg_rsp_o.rdata = 32'(pending_q);
      periph_pkg::PLIC_ENABLE_OFFSET:  reg_rsp_o.rdata = 32'(enable_q);
      periph_pkg::PLIC_CLAIM_OFFSET:   reg_rsp_o.rdata = claim_id;
      periph_pkg::PLIC_MSIP_OFFSET:    reg_rsp_o.rdata = {31'b0, msip_q};
      default:                         reg_rsp_o.rdata = '0;
    endcase
  end

  assign irq_o  = |active;
  assign msip_o = msip_q;

endmodule : plic_lite

//--- rtl/reg_demux.sv
// --------------------------------------------------
// Register bus decoder: routes each access to one
// slot and registers the returned read data
// --------------------------------------------------
`timescale 1ns/1ps

module reg_demux (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  periph_pkg::reg_req_t                              reg_req_i,
  output logic [31:0]                                       reg_rdata_o,
  output logic                                              reg_rvalid_o,
  output periph_pkg::reg_req_t [periph_pkg::NUM_PERIPH-1:0] slv_req_o,
  input  periph_pkg::reg_rsp_t [periph_pkg::NUM_PERIPH-1:0] slv_rsp_i
);

  logic [periph_pkg::SEL_W-1:0] sel;
  logic [31:0]                  rdata_d;
  logic [31:0]                  rdata_q;
  logic                         rvalid_q;

  assign sel = reg_req_i.addr[periph_pkg::SEL_LSB +: periph_pkg::SEL_W];

  // Only the selected slot sees valid, with a slot-relative address
  always_comb begin
    for (int i = 0; i < periph_pkg::NUM_PERIPH; i++) begin
      slv_req_o[i].valid = reg_req_i.valid && (sel == i);
      slv_req_o[i].write = reg_req_i.write;
      slv_req_o[i].addr  = 32'(reg_req_i.addr[periph_pkg::SEL_LSB-1:0]);
      slv_req_o[i].wdata = reg_req_i.wdata;
    end
  end

  always_comb begin
    if (reg_req_i.write) begin
      rdata_d = '0;
    end else if (sel == periph_pkg::UNMAPPED_IDX) begin
      rdata_d = periph_pkg::DEC_ERR_DATA;
    end else begin
      rdata_d = slv_rsp_i[sel].rdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= reg_req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_req_i.valid) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rdata_o  = rdata_q;
  assign reg_rvalid_o = rvalid_q;

endmodule : reg_demux

//--- rtl/timer.sv
// --------------------------------------------------
// Compare timer: free-running counter with a sticky
// expiry interrupt on compare match
// --------------------------------------------------
`timescale 1ns/1ps

module timer (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                 intr_o
);

  logic                           wr_en;
  logic [periph_pkg::SEL_LSB-1:0] offset;
  logic [31:0]                    count_q;
  logic [31:0]                    compare_q;
  logic                           enable_q;
  logic                           status_q;
  logic                           match;
  logic                           status_clr;

  assign wr_en  = reg_req_i.valid & reg_req_i.write;
  assign offset = reg_req_i.addr[periph_pkg::SEL_LSB-1:0];

  assign match      = enable_q && (count_q == compare_q);
  assign status_clr = wr_en && (offset == periph_pkg::TIMER_STATUS_OFFSET) &&
                      reg_req_i.wdata[0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q   <= '0;
      compare_q <= '0;
      enable_q  <= 1'b0;
      status_q  <= 1'b0;
    end else begin
      // Software write to COUNT overrides the increment
      if (wr_en && offset == periph_pkg::TIMER_COUNT_OFFSET) begin
        count_q <= reg_req_i.wdata;
      end else if (enable_q) begin
        count_q <= count_q + 32'd1;
      end
      if (wr_en && offset == periph_pkg::TIMER_COMPARE_OFFSET) begin
        compare_q <= reg_req_i.wdata;
      end
      if (wr_en && offset == periph_pkg::TIMER_CTRL_OFFSET) begin
        enable_q <= reg_req_i.wdata[0];
      end
      // Sticky until cleared, match has priority
      if (match) begin
        status_q <= 1'b1;
      end else if (status_clr) begin
        status_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (offset)
      periph_pkg::TIMER_COUNT_OFFSET:   reg_rsp_o.rdata = count_q;
      periph_pkg::TIMER_COMPARE_OFFSET: reg_rsp_o.rdata = compare_q;
      periph_pkg::TIMER_CTRL_OFFSET:    reg_rsp_o.rdata = {31'b0, enable_q};
      periph_pkg::TIMER_STATUS_OFFSET:  reg_rsp_o.rdata = {31'b0, status_q};
      default:                          reg_rsp_o.rdata = '0;
    endcase
  end

  assign intr_o = status_q;

endmodule : timer

//--- sim.f
rtl/periph_pkg.sv
rtl/obi_to_reg.sv
rtl/reg_demux.sv
rtl/gpio.sv
rtl/timer.sv
rtl/plic_lite.sv
rtl/peripheral_subsystem.sv
verification/tb_clk_gen.sv
verification/peripheral_subsystem_asserts.sv
verification/tb_peripheral_subsystem.sv

//--- verification/periph_tests.txt
# Columns: name, operation, address, value, expected (hex)
# Operations: wr, rd, b2b, pins, ext, wait (value in cycles), irq, msip, gpo, gpoe
gpio_out_wr        wr    100 000000a5 00000000
gpio_out_rd        rd    100 00000000 000000a5
gpio_out_pin       gpo   000 00000000 000000a5
gpio_oe_wr         wr    104 0000003c 00000000
gpio_oe_rd         rd    104 00000000 0000003c
gpio_oe_pin        gpoe  000 00000000 0000003c
tmr_cmp_wr         wr    204 00000010 00000000
tmr_cmp_rd         rd    204 00000000 00000010
plic_en_wr         wr    004 00000002 00000000
plic_en_rd         rd    004 00000000 00000002
msip_wr            wr    00c 00000001 00000000
msip_pin           msip  000 00000000 00000001
unmapped_rd        rd    300 00000000 deadbeef
b2b_intr_en        b2b   10c 00000001 00000001
gpio_pins          pins  000 00000001 00000000
gpio_settle        wait  000 00000008 00000000
gpio_in_rd         rd    108 00000000 00000001
gpio_stat_rd       rd    110 00000000 00000001
gpio_irq_on        irq   000 00000000 00000001
gpio_stat_clr      wr    110 00000001 00000000
gpio_claim         rd    008 00000000 00000001
gpio_irq_off       irq   000 00000000 00000000
tmr_enable         wr    208 00000001 00000000
tmr_run            wait  000 0000001e 00000000
tmr_stat_rd        rd    20c 00000000 00000001
plic_en_tmr        wr    004 00000004 00000000
tmr_claim          rd    008 00000000 00000002
tmr_stat_clr       wr    20c 00000001 00000000
tmr_disable        wr    208 00000000 00000000
tmr_claim_again    rd    008 00000000 00000002
tmr_irq_off        irq   000 00000000 00000000
ext_set            ext   000 00000005 00000000
plic_en_all        wr    004 0000007e 00000000
ext_drop_id3       ext   000 00000004 00000000
ext_claim_first    rd    008 00000000 00000003
ext_claim_next     rd    008 00000000 00000005
ext_clear          ext   000 00000000 00000000
ext_claim_last     rd    008 00000000 00000005
ext_claim_none     rd    008 00000000 00000000
ext_irq_off        irq   000 00000000 00000000

//--- verification/peripheral_subsystem_asserts.sv
// --------------------------------------------------
// Bus handshake, reset and interrupt checks bound
// into the peripheral subsystem
// --------------------------------------------------
`timescale 1ns/1ps

module peripheral_subsystem_asserts (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input periph_pkg::obi_req_t  obi_req_i,
  input periph_pkg::obi_resp_t obi_resp_i,
  input logic                  irq_i
);

  logic accepted;
  int   fail_count;

  assign accepted = obi_req_i.req & obi_resp_i.gnt;

  // Handshake stays quiet while reset is held
  reset_quiet_a: assert property (@(posedge clk_i)
    !rst_n_i |-> !obi_resp_i.gnt && !obi_resp_i.rvalid)
    else begin
      $error("gnt or rvalid is high during reset");
      fail_count++;
    end

  rvalid_latency_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accepted |-> ##2 obi_resp_i.rvalid)
    else begin
      $error("accepted request got no rvalid two cycles later");
      fail_count++;
    end

  // Every response belongs to a request accepted two cycles before
  rvalid_origin_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    obi_resp_i.rvalid |-> $past(accepted, 2))
    else begin
      $error("rvalid without a request accepted two cycles earlier");
      fail_count++;
    end

  irq_known_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(irq_i))
    else begin
      $error("irq_plic_o is unknown after reset");
      fail_count++;
    end

endmodule : peripheral_subsystem_asserts

bind peripheral_subsystem peripheral_subsystem_asserts asserts0 (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .obi_req_i (obi_req_i),
  .obi_resp_i(obi_resp_o),
  .irq_i     (irq_plic_o)
);

//--- verification/tb_clk_gen.sv
// --------------------------------------------------
// Testbench clock source with a 10 ns period
// --------------------------------------------------
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  initial clk_o = 1'b0;

  // Half period of 5 ns
  always #5 clk_o = ~clk_o;

endmodule : tb_clk_gen

//--- verification/tb_peripheral_subsystem.sv
// --------------------------------------------------
// Peripheral subsystem testbench: runs the vectors of
// the tests file over the bus and the pins
// --------------------------------------------------
`timescale 1ns/1ps

module tb_peripheral_subsystem;

  logic                            clk;
  logic                            rst_n;
  periph_pkg::obi_req_t            obi_req;
  periph_pkg::obi_resp_t           obi_resp;
  logic [periph_pkg::NEXT_INT-1:0] intr_ext;
  logic                            irq_plic;
  logic                            msip;
  logic [periph_pkg::GPIO_W-1:0]   gpio_in;
  logic [periph_pkg::GPIO_W-1:0]   gpio_out;
  logic [periph_pkg::GPIO_W-1:0]   gpio_oe;

  string       names[$];
  string       ops[$];
  logic [31:0] addrs[$];
  logic [31:0] values[$];
  logic [31:0] expects[$];
  int          num_tests;
  int          failed_tests;
  int          test_errors;

  tb_clk_gen clk_gen0 (.clk_o(clk));

  peripheral_subsystem dut0 (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .obi_req_i (obi_req),
    .obi_resp_o(obi_resp),
    .intr_ext_i(intr_ext),
    .irq_plic_o(irq_plic),
    .msip_o    (msip),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_oe_o (gpio_oe)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in test %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic report_error(input string name, input string what);
    $display("Error in test %s: %s", name, what);
    test_errors++;
  endtask

  // Columns: name, operation, address, value, expected value
  task automatic load_tests(output bit loaded);
    int          fd;
    int          rc;
    string       line;
    string       name;
    string       op;
    logic [31:0] addr;
    logic [31:0] value;
    logic [31:0] expected;
    fd = $fopen("verification/periph_tests.txt", "r");
    loaded = (fd != 0);
    if (loaded) begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        if (rc > 0 && line.len() > 0 && line[0] != "#") begin
          rc = $sscanf(line, "%s %s %h %h %h", name, op, addr, value, expected);
          if (rc == 5) begin
            names.push_back(name);
            ops.push_back(op);
            addrs.push_back(addr);
            values.push_back(value);
            expects.push_back(expected);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Starts at a rising edge and returns at the edge that accepts the request
  task automatic issue_request(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, output bit granted);
    int cycles;
    cycles = 0;
    granted = 1'b0;
    obi_req <= '{req: 1'b1, we: we, addr: addr, wdata: wdata};
    while (!granted && cycles < 20) begin
      @(negedge clk);
      granted = obi_resp.gnt;
      cycles++;
      @(posedge clk);
    end
  endtask

  task automatic collect_response(output logic [31:0] rdata, output bit seen);
    int cycles;
    cycles = 0;
    seen = 1'b0;
    rdata = '0;
    while (!seen && cycles < 10) begin
      @(negedge clk);
      seen = obi_resp.rvalid;
      rdata = obi_resp.rdata;
      cycles++;
    end
  endtask

  task automatic run_test(input int idx);
    string       name;
    logic [31:0] rdata;
    bit          ok;
    name = names[idx];
    test_errors = 0;
    @(posedge clk);
    case (ops[idx])
      "wr", "rd": begin
        issue_request(ops[idx] == "wr", addrs[idx], values[idx], ok);
        obi_req.req <= 1'b0;
        if (!ok) begin
          report_error(name, "the request was never granted");
        end else begin
          collect_response(rdata, ok);
          if (!ok) begin
            report_error(name, "no response arrived");
          end else begin
            check_value(name, expects[idx], rdata);
          end
        end
      end
      "b2b": begin
        // Write then read the same register on consecutive cycles
        issue_request(1'b1, addrs[idx], values[idx], ok);
        if (ok) begin
          issue_request(1'b0, addrs[idx], 32'h0, ok);
        end
        obi_req.req <= 1'b0;
        if (!ok) begin
          report_error(name, "a back-to-back request was never granted");
        end
        for (int k = 0; k < 2 && ok; k++) begin
          collect_response(rdata, ok);
          if (!ok) begin
            report_error(name, "a back-to-back response is missing");
          end else begin
            check_value(name, (k == 0) ? 32'h0 : expects[idx], rdata);
          end
        end
      end
      "pins": gpio_in <= values[idx][periph_pkg::GPIO_W-1:0];
      "ext": intr_ext <= values[idx][periph_pkg::NEXT_INT-1:0];
      "wait": repeat (values[idx]) @(posedge clk);
      "irq", "msip", "gpo", "gpoe": begin
        @(negedge clk);
        case (ops[idx])
          "irq": check_value(name, expects[idx], 32'(irq_plic));
          "msip": check_value(name, expects[idx], 32'(msip));
          "gpo": check_value(name, expects[idx], 32'(gpio_out));
          default: check_value(name, expects[idx], 32'(gpio_oe));
        endcase
      end
      default: report_error(name, "the operation is not known");
    endcase
    if (test_errors != 0) begin
      failed_tests++;
    end
    $display("%-18s %-5s %s", name, ops[idx], (test_errors == 0) ? "ok" : "failed");
  endtask

  initial begin
    bit loaded;
    obi_req      = '0;
    intr_ext     = '0;
    gpio_in      = '0;
    rst_n        <= 1'b0;
    num_tests    = 0;
    failed_tests = 0;
    test_errors  = 0;
    load_tests(loaded);
    if (!loaded || names.size() == 0) begin
      $display("Could not read any test from verification/periph_tests.txt");
      $display("=== FAIL ===");
      $finish;
    end else begin
      num_tests = names.size();
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < num_tests; i++) begin
        run_test(i);
      end
      $display("Tests run: %0d, passed: %0d, failed: %0d, assertion failures: %0d",
               num_tests, num_tests - failed_tests, failed_tests,
               dut0.asserts0.fail_count);
      if (failed_tests == 0 && dut0.asserts0.fail_count == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

  // Budget of 50 cycles per test plus some slack
  initial begin
    wait (num_tests > 0);
    repeat ((num_tests + 10) * 50) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", (num_tests + 10) * 50);
    $display("=== FAIL ===");
    $finish;
  end

endmodule : tb_peripheral_subsystem
